// ==== aesStatePkg.sv ====
// AES state types
package aesStatePkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int stateBits = 128; // block and key width.
  localparam int colBits   = 32;

  // ------------------------------
  // types
  // ------------------------------
  typedef logic [7:0] byteT;

  // row 0 sits in the top byte.
  typedef byteT [0:colBits/8-1] columnT;

  // the same 128 bits seen as bytes or as columns.
  // byte 4*c+r is row r of column c, column 0 in the top word.
  typedef union packed {
    byteT   [0:stateBits/8-1]       bytes;
    columnT [0:stateBits/colBits-1] cols;
  } stateT;

endpackage

// ==== aesRoundPkg.sv ====
// AES round sequencing
package aesRoundPkg;

  localparam int numRounds = 10;

  // one-hot round marker.
  // bit 0 is the first expansion step and also the final round.
  typedef logic [numRounds-1:0] roundT;

  localparam roundT firstRound = roundT'(1);

  // ------------------------------
  // round constants
  // ------------------------------
  // entry k belongs to one-hot bit k.
  localparam logic [numRounds-1:0][7:0] rconTable = {
    8'h36, 8'h1b, 8'h80, 8'h40, 8'h20,
    8'h10, 8'h08, 8'h04, 8'h02, 8'h01
  };

endpackage

// ==== aesSBox.sv ====
// AES forward S-box
`timescale 1ns/1ns

module aesSBox (
  input  aesStatePkg::columnT col,
  output aesStatePkg::columnT subCol
);

  // entry 0 is the top byte, sixteen entries per row.
  localparam logic [0:255][7:0] sboxTable = {
    128'h637c777b_f26b6fc5_3001672b_fed7ab76,
    128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
    128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
    128'h04c723c3_1896059a_071280e2_eb27b275,
    128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
    128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
    128'hd0efaafb_434d3385_45f9027f_503c9fa8,
    128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
    128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
    128'h60814fdc_222a9088_46eeb814_de5e0bdb,
    128'he0323a0a_4906245c_c2d3ac62_9195e479,
    128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
    128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
    128'h703eb566_4803f60e_613557b9_86c11d9e,
    128'he1f89811_69d98e94_9b1e87e9_ce5528df,
    128'h8ca1890d_bfe64268_41992d0f_b054bb16
  };

  // byte order is kept.
  always_comb begin
    for (int i = 0; i < $size(col); i++) begin
      subCol[i] = sboxTable[col[i]];
    end
  end

endmodule

// ==== aesMixColumn.sv ====
// AES MixColumns for one column
`timescale 1ns/1ns

module aesMixColumn (
  input  aesStatePkg::columnT col,
  output aesStatePkg::columnT mixCol
);

  aesStatePkg::byteT b01, b12, b23, b30; // neighbour sums.

  // multiply by 2 in GF(2^8).
  function automatic aesStatePkg::byteT xtime(aesStatePkg::byteT a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  assign b01 = col[0] ^ col[1];
  assign b12 = col[1] ^ col[2];
  assign b23 = col[2] ^ col[3];
  assign b30 = col[3] ^ col[0];

  // 2a ^ 3b ^ c ^ d written as 2(a^b) ^ b ^ (c^d).
  assign mixCol[0] = xtime(b01) ^ col[1] ^ b23;
  assign mixCol[1] = xtime(b12) ^ col[2] ^ b30;
  assign mixCol[2] = xtime(b23) ^ col[3] ^ b01;
  assign mixCol[3] = xtime(b30) ^ col[0] ^ b12;

endmodule

// ==== aesRoundDatapath.sv ====
// AES encryption round datapath
`timescale 1ns/1ns

module aesRoundDatapath (
  input  logic               CLK,
  input  logic               startBlock,
  input  logic               roundStep,
  input  aesRoundPkg::roundT round,
  input  aesStatePkg::stateT Din,
  input  aesStatePkg::stateT roundKey,
  output aesStatePkg::stateT state
);

  aesStatePkg::stateT subState;
  aesStatePkg::stateT shiftState;
  aesStatePkg::stateT mixState;
  aesStatePkg::stateT nextState;

  // ------------------------------
  // SubBytes and MixColumns
  // ------------------------------
  for (genvar c = 0; c < 4; c++) begin : gCol
    aesSBox u_aesSBox (
      .col    (state.cols[c]),
      .subCol (subState.cols[c])
    );

    aesMixColumn u_aesMixColumn (
      .col    (shiftState.cols[c]),
      .mixCol (mixState.cols[c])
    );
  end

  // ShiftRows. row r moves left by r columns.
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shiftState.bytes[4*c + r] = subState.bytes[4*((c + r) % 4) + r];
      end
    end
  end

  // final round has no MixColumns.
  assign nextState = (round[0] ? shiftState : mixState) ^ roundKey;

  // ------------------------------
  // state register
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (startBlock) begin
      state <= Din ^ roundKey; // initial AddRoundKey.
    end else if (roundStep) begin
      state <= nextState;
    end
  end

endmodule

// ==== aesKeySchedule.sv ====
// AES-128 key expansion
`timescale 1ns/1ns

module aesKeySchedule (
  input  logic               CLK,
  input  logic               loadKey,
  input  logic               startBlock,
  input  logic               roundStep,
  input  logic               finishBlock,
  input  aesRoundPkg::roundT round,
  input  aesStatePkg::stateT Key,
  output aesStatePkg::stateT roundKey
);

  aesStatePkg::stateT  cipherKey;
  aesStatePkg::stateT  workKey;
  aesStatePkg::stateT  nextKey;
  aesStatePkg::columnT rotWord;
  aesStatePkg::columnT subWord;
  aesStatePkg::byteT   rcon;

  assign roundKey = workKey; // cipher key while idle.

  // RotWord of the last column.
  assign rotWord = {workKey.cols[3][1], workKey.cols[3][2],
                    workKey.cols[3][3], workKey.cols[3][0]};

  aesSBox u_aesSBox (
    .col    (rotWord),
    .subCol (subWord)
  );

  // one-hot select of the round constant.
  always_comb begin
    rcon = '0;
    for (int k = 0; k < aesRoundPkg::numRounds; k++) begin
      if (round[k]) begin
        rcon = rcon | aesRoundPkg::rconTable[k];
      end
    end
  end

  // each column chains off the one before.
  always_comb begin
    nextKey.cols[0] = workKey.cols[0] ^ {subWord[0] ^ rcon, subWord[1], subWord[2], subWord[3]};
    for (int i = 1; i < 4; i++) begin
      nextKey.cols[i] = workKey.cols[i] ^ nextKey.cols[i-1];
    end
  end

  // ------------------------------
  // key registers
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (loadKey) begin
      cipherKey <= Key;
      workKey   <= Key;
    end else if (finishBlock) begin
      workKey <= cipherKey; // ready for the next block.
    end else if (startBlock || roundStep) begin
      workKey <= nextKey;
    end
  end

endmodule

// ==== aesControl.sv ====
// AES round sequencer
`timescale 1ns/1ns

module aesControl (
  input  logic               CLK,
  input  logic               RST,
  input  logic               EN,
  input  logic               Keyrdy,
  input  logic               Datardy,
  output logic               loadKey,
  output logic               startBlock,
  output logic               roundStep,
  output logic               finishBlock,
  output aesRoundPkg::roundT round,
  output logic               BSY,
  output logic               Dvld
);

  aesRoundPkg::roundT nextRound;

  // ------------------------------
  // enables
  // ------------------------------
  // Keyrdy wins when both strobes arrive together.
  assign loadKey     = !BSY && EN && Keyrdy;
  assign startBlock  = !BSY && EN && !Keyrdy && Datardy;
  assign roundStep   = BSY && EN;
  assign finishBlock = roundStep && round[0];

  assign nextRound = {round[aesRoundPkg::numRounds-2:0], round[aesRoundPkg::numRounds-1]};

  // ------------------------------
  // round counter and flags
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (!RST) begin
      round <= aesRoundPkg::firstRound;
      BSY   <= 1'b0;
      Dvld  <= 1'b0;
    end else begin
      if (loadKey) begin
        Dvld <= 1'b0;
      end
      if (startBlock) begin
        round <= nextRound;
        BSY   <= 1'b1;
        Dvld  <= 1'b0;
      end
      if (finishBlock) begin
        BSY  <= 1'b0; // round stays on bit 0 for the next block.
        Dvld <= 1'b1;
      end else if (roundStep) begin
        round <= nextRound;
      end
    end
  end

endmodule

// ==== aesEncryptor.sv ====
// AES-128 iterative encryptor
`timescale 1ns/1ns

module aesEncryptor (
  input  logic               CLK,
  input  logic               RST,
  input  logic               EN,
  input  logic               Keyrdy,
  input  logic               Datardy,
  input  aesStatePkg::stateT Key,
  input  aesStatePkg::stateT Din,
  output aesStatePkg::stateT Dout,
  output logic               BSY,
  output logic               Dvld
);

  logic               loadKey;
  logic               startBlock;
  logic               roundStep;
  logic               finishBlock;
  aesRoundPkg::roundT round;
  aesStatePkg::stateT roundKey;

  // ------------------------------
  // sequencer
  // ------------------------------
  aesControl u_aesControl (
    .CLK         (CLK),
    .RST         (RST),
    .EN          (EN),
    .Keyrdy      (Keyrdy),
    .Datardy     (Datardy),
    .loadKey     (loadKey),
    .startBlock  (startBlock),
    .roundStep   (roundStep),
    .finishBlock (finishBlock),
    .round       (round),
    .BSY         (BSY),
    .Dvld        (Dvld)
  );

  // ------------------------------
  // datapaths
  // ------------------------------
  aesRoundDatapath u_aesRoundDatapath (
    .CLK        (CLK),
    .startBlock (startBlock),
    .roundStep  (roundStep),
    .round      (round),
    .Din        (Din),
    .roundKey   (roundKey),
    .state      (Dout)
  );

  aesKeySchedule u_aesKeySchedule (
    .CLK         (CLK),
    .loadKey     (loadKey),
    .startBlock  (startBlock),
    .roundStep   (roundStep),
    .finishBlock (finishBlock),
    .round       (round),
    .Key         (Key),
    .roundKey    (roundKey)
  );

endmodule

// ==== tbClockGen.sv ====
// Testbench clock and reset
`timescale 1ns/1ns

module tbClockGen (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK; // 8 ns period.
  end

  // synchronous reset held low for 10 cycles.
  initial begin
    RST = 1'b0;
    repeat (10) @(posedge CLK);
    RST <= 1'b1;
  end

endmodule

// ==== aesEncryptor_tb.sv ====
// AES-128 encryptor testbench
`timescale 1ns/1ns

module aesEncryptor_tb;

  localparam int numVectors = 6;

  localparam logic [1:0] keyReuse = 2'd0; // keep the last loaded key.
  localparam logic [1:0] keyLoad  = 2'd1;
  localparam logic [1:0] keyBoth  = 2'd2; // Keyrdy and Datardy together.

  typedef struct packed {
    aesStatePkg::stateT key;
    aesStatePkg::stateT pt;
    aesStatePkg::stateT ct;
    logic [1:0]         keyMode;
    logic               disturb; // poke inputs mid-block.
    logic [3:0]         stall;   // EN low cycles while busy.
  } vectorT;

  logic               CLK;
  logic               RST;
  logic               EN;
  logic               Keyrdy;
  logic               Datardy;
  aesStatePkg::stateT Key;
  aesStatePkg::stateT Din;
  aesStatePkg::stateT Dout;
  logic               BSY;
  logic               Dvld;

  vectorT vectors [numVectors];
  integer seed;
  int     errorCount;
  int     checkCount;

  tbClockGen u_tbClockGen (
    .CLK (CLK),
    .RST (RST)
  );

  aesEncryptor u_aesEncryptor (
    .CLK     (CLK),
    .RST     (RST),
    .EN      (EN),
    .Keyrdy  (Keyrdy),
    .Datardy (Datardy),
    .Key     (Key),
    .Din     (Din),
    .Dout    (Dout),
    .BSY     (BSY),
    .Dvld    (Dvld)
  );

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic checkState(input string name, input aesStatePkg::stateT got,
                            input aesStatePkg::stateT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // ------------------------------
  // stimulus table
  // ------------------------------
  function automatic vectorT makeEntry(input aesStatePkg::stateT key,
                                       input aesStatePkg::stateT pt,
                                       input aesStatePkg::stateT ct,
                                       input logic [1:0] keyMode,
                                       input logic disturb,
                                       input logic [3:0] stall);
    vectorT v;
    v.key     = key;
    v.pt      = pt;
    v.ct      = ct;
    v.keyMode = keyMode;
    v.disturb = disturb;
    v.stall   = stall;
    return v;
  endfunction

  task automatic buildTable();
    aesStatePkg::stateT keyA;
    aesStatePkg::stateT ptA;
    aesStatePkg::stateT ctA;
    aesStatePkg::stateT keyB;
    aesStatePkg::stateT ptB;
    aesStatePkg::stateT ctB;
    aesStatePkg::stateT ctZ;
    keyA = 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c; // FIPS-197 appendix B.
    ptA  = 128'h3243f6a8_885a308d_313198a2_e0370734;
    ctA  = 128'h3925841d_02dc09fb_dc118597_196a0b32;
    keyB = 128'h00010203_04050607_08090a0b_0c0d0e0f; // appendix C.1.
    ptB  = 128'h00112233_44556677_8899aabb_ccddeeff;
    ctB  = 128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a;
    ctZ  = 128'h66e94bd4_ef8a2c3b_884cfa59_ca342b2e;
    vectors[0] = makeEntry(keyA, ptA, ctA, keyLoad, 1'b0, 4'd0);
    vectors[1] = makeEntry(keyB, ptB, ctB, keyLoad, 1'b0, 4'd3);
    vectors[2] = makeEntry(keyB, ptB, ctB, keyReuse, 1'b1, 4'd0);
    vectors[3] = makeEntry('0, '0, ctZ, keyBoth, 1'b0, 4'd5);
    vectors[4] = makeEntry('0, '0, ctZ, keyReuse, 1'b1, 4'd2);
    vectors[5] = makeEntry(keyA, ptA, ctA, keyLoad, 1'b1, 4'd4);
  endtask

  function automatic int maxStall();
    int m;
    m = 0;
    for (int i = 0; i < numVectors; i++) begin
      if (int'(vectors[i].stall) > m) begin
        m = int'(vectors[i].stall);
      end
    end
    return m;
  endfunction

  // ------------------------------
  // drive sequences
  // ------------------------------
  // Keyrdy alone, or with Datardy to check that the key wins.
  task automatic applyKey(input vectorT v);
    @(posedge CLK);
    Key     <= v.key;
    Din     <= v.pt;
    Keyrdy  <= 1'b1;
    Datardy <= (v.keyMode == keyBoth);
    EN      <= 1'b1;
    @(posedge CLK);
    Keyrdy  <= 1'b0;
    Datardy <= 1'b0;
    @(negedge CLK);
    checkFlag("BSY", BSY, 1'b0);
    checkFlag("Dvld", Dvld, 1'b0);
  endtask

  task automatic runBlock(input int idx, input vectorT v);
    int                 edges;
    int                 stalled;
    int                 stallAt;
    int                 latency;
    logic               enLow;
    logic               lastLow;
    logic               done;
    aesStatePkg::stateT held;
    stallAt = {$random(seed)} % 10; // always before the last round.
    latency = 10 + int'(v.stall);
    stalled = 0;
    edges   = 0;
    enLow   = 1'b0;
    done    = 1'b0;
    held    = '0;
    @(posedge CLK);
    Din     <= v.pt;
    Key     <= ~v.key; // no longer the loaded key.
    Datardy <= 1'b1;
    EN      <= 1'b1;
    @(posedge CLK); // edge 0 samples Datardy.
    while (!done) begin
      lastLow = enLow;
      enLow   = (edges >= stallAt) && (stalled < int'(v.stall));
      if (enLow) begin
        stalled++;
      end
      EN      <= !enLow;
      Keyrdy  <= v.disturb && (edges == 3);
      Datardy <= v.disturb && (edges == 5);
      if (v.disturb && edges == 3) begin
        Din <= ~v.pt;
        Key <= v.key;
      end
      @(negedge CLK);
      checkFlag("BSY", BSY, edges < latency);
      checkFlag("Dvld", Dvld, edges == latency);
      if (lastLow) begin
        checkState("Dout", Dout, held); // frozen while EN is low.
      end
      held = Dout;
      if (Dvld || edges > latency + 2) begin
        done = 1'b1;
      end else begin
        @(posedge CLK);
        edges++;
      end
    end
    if (!Dvld) begin
      errorCount++;
      $display("Error: block %0d raised no Dvld within %0d edges", idx, edges);
    end
    checkState("Dout", Dout, v.ct);
    // result must hold until the next start.
    repeat (2) begin
      @(negedge CLK);
      checkFlag("Dvld", Dvld, 1'b1);
      checkFlag("BSY", BSY, 1'b0);
      checkState("Dout", Dout, v.ct);
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    EN         = 1'b0;
    Keyrdy     = 1'b0;
    Datardy    = 1'b0;
    Key        = '0;
    Din        = '0;
    seed       = 29289;
    errorCount = 0;
    checkCount = 0;
    buildTable();
    wait (RST === 1'b1);
    @(negedge CLK);
    checkFlag("BSY", BSY, 1'b0);
    checkFlag("Dvld", Dvld, 1'b0);
    for (int i = 0; i < numVectors; i++) begin
      if (vectors[i].keyMode != keyReuse) begin
        applyKey(vectors[i]);
      end
      runBlock(i, vectors[i]);
    end
    $display("Done: %0d errors in %0d checks", errorCount, checkCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog sized from the table.
  initial begin
    int limit;
    wait (RST === 1'b1);
    limit = 2 * numVectors * (11 + maxStall()) * 8;
    #(limit);
    $display("Timeout: tests did not finish within %0d ns after reset", limit);
    $display("Done: %0d errors in %0d checks", errorCount, checkCount);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== aesEncryptor.f ====
aesStatePkg.sv
aesRoundPkg.sv
aesSBox.sv
aesMixColumn.sv
aesRoundDatapath.sv
aesKeySchedule.sv
aesControl.sv
aesEncryptor.sv
tbClockGen.sv
aesEncryptor_tb.sv
